/* rtl/csi2_rx_pkg.sv */
// ----------------------------------------------------------
// shared types for the CSI-2 receive path
// widths, valid-only beat structs and CSI-2 data types
// ----------------------------------------------------------

package csi2_rx_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [9:0]  pixel_t;
    typedef logic [5:0]  data_type_t;
    typedef logic [15:0] word_count_t;
    typedef logic [15:0] crc_t;

    // ------------------------------------------------------
    // CSI-2 data types
    // ------------------------------------------------------
    localparam data_type_t dt_frame_start = 6'h00;
    localparam data_type_t dt_frame_end   = 6'h01;
    localparam data_type_t dt_raw10       = 6'h2b;

    // ------------------------------------------------------
    // stream beats
    // ------------------------------------------------------
    // merged lane byte
    typedef struct packed {
        logic  sop;
        byte_t data;
    } byte_beat_t;

    // long packet payload byte
    typedef struct packed {
        logic  fs;
        logic  last;
        byte_t data;
    } payload_beat_t;

    // unpacked pixel, user marks frame start and last marks line end
    typedef struct packed {
        logic   user;
        logic   last;
        pixel_t data;
    } pixel_beat_t;

endpackage

/* rtl/csi2_lane_merge.sv */
// ----------------------------------------------------------
// merges the D-PHY lane bytes into one byte stream
// a lane beat is captured whole and shifted out lane 0 first,
// the source leaves at least lanes-1 idle cycles between beats
// ----------------------------------------------------------

module csi2_lane_merge #(
    parameter int lanes = 2
) (
    input  logic                     aclk,
    input  logic                     aresetn,
    input  logic [lanes*8-1:0]       rxdatahs,
    input  logic [lanes-1:0]         rxvalidhs,
    input  logic [lanes-1:0]         rxsynchs,
    output logic                     byte_valid,
    output csi2_rx_pkg::byte_beat_t  byte_beat
);

    import csi2_rx_pkg::*;

    localparam int cnt_w = $clog2(lanes + 1);

    logic                  lane_beat;
    byte_t [lanes-1:0]     shift_q;
    logic  [cnt_w-1:0]     remain;

    // all lanes must deliver together
    assign lane_beat = &rxvalidhs;

    // ------------------------------------------------------
    // control
    // ------------------------------------------------------
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            byte_valid <= 1'b0;
            remain     <= '0;
        end else begin
            byte_valid <= 1'b0;
            if (lane_beat) begin
                byte_valid <= 1'b1;
                remain     <= cnt_w'(lanes - 1);
            end else if (remain != '0) begin
                byte_valid <= 1'b1;
                remain     <= remain - 1'b1;
            end
        end
    end

    // ------------------------------------------------------
    // byte shifter
    // ------------------------------------------------------
    always_ff @(posedge aclk) begin
        if (lane_beat) begin
            byte_beat.sop  <= |rxsynchs;
            byte_beat.data <= rxdatahs[7:0];
            // lane 0 goes out now, the rest wait in the shifter
            shift_q        <= rxdatahs >> 8;
        end else if (remain != '0) begin
            byte_beat.sop  <= 1'b0;
            byte_beat.data <= shift_q[0];
            shift_q        <= shift_q >> 8;
        end
    end

endmodule

/* rtl/csi2_packet_parser.sv */
// ----------------------------------------------------------
// CSI-2 packet parser on the merged byte stream
// forwards payload of the selected data type, checks the
// CRC-16 of every long packet and flags frame start/end
// ----------------------------------------------------------

module csi2_packet_parser #(
    parameter csi2_rx_pkg::data_type_t pixel_data_type = csi2_rx_pkg::dt_raw10
) (
    input  logic                        aclk,
    input  logic                        aresetn,
    input  logic                        byte_valid,
    input  csi2_rx_pkg::byte_beat_t     byte_beat,
    output logic                        payload_valid,
    output csi2_rx_pkg::payload_beat_t  payload_beat,
    output logic                        frame_start,
    output logic                        frame_end,
    output logic                        crc_error
);

    import csi2_rx_pkg::*;

    typedef enum logic [2:0] {
        idle,
        header,
        payload,
        crc,
        pad
    } state_t;

    state_t      state;
    logic [1:0]  idx;
    data_type_t  dt;
    byte_t       lo_byte;
    word_count_t remain;
    crc_t        crc_acc;
    logic        fs_pending;

    // reflected poly 0x8408, data taken LSB first
    function automatic crc_t crc_next(crc_t c, byte_t d);
        crc_t r;
        r = c;
        for (int i = 0; i < 8; i++) begin
            if (r[0] ^ d[i]) begin
                r = (r >> 1) ^ 16'h8408;
            end else begin
                r = r >> 1;
            end
        end
        return r;
    endfunction

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            state         <= idle;
            idx           <= '0;
            fs_pending    <= 1'b0;
            payload_valid <= 1'b0;
            frame_start   <= 1'b0;
            frame_end     <= 1'b0;
            crc_error     <= 1'b0;
        end else begin
            payload_valid <= 1'b0;
            frame_start   <= 1'b0;
            frame_end     <= 1'b0;
            crc_error     <= 1'b0;

            if (byte_valid && byte_beat.sop) begin
                // byte 0 is DI
                state <= header;
                idx   <= 2'd1;
                dt    <= byte_beat.data[5:0];
            end else if (byte_valid) begin
                case (state)
                    header: begin
                        idx <= idx + 1'b1;
                        case (idx)
                            2'd1: lo_byte <= byte_beat.data;
                            2'd2: remain  <= {byte_beat.data, lo_byte};
                            default: begin
                                // ECC byte, not checked
                                crc_acc <= 16'hffff;
                                idx     <= '0;
                                if (dt[5:4] == 2'b00) begin
                                    // types 0x00-0x0f are short packets
                                    state       <= idle;
                                    frame_start <= (dt == dt_frame_start);
                                    frame_end   <= (dt == dt_frame_end);
                                    if (dt == dt_frame_start) begin
                                        fs_pending <= 1'b1;
                                    end
                                end else if (remain == '0) begin
                                    state <= crc;
                                end else begin
                                    state <= payload;
                                end
                            end
                        endcase
                    end

                    payload: begin
                        crc_acc <= crc_next(crc_acc, byte_beat.data);
                        remain  <= remain - 1'b1;
                        if (dt == pixel_data_type) begin
                            payload_valid      <= 1'b1;
                            payload_beat.data  <= byte_beat.data;
                            payload_beat.last  <= (remain == 16'd1);
                            payload_beat.fs    <= fs_pending;
                            fs_pending         <= 1'b0;
                        end
                        if (remain == 16'd1) begin
                            state <= crc;
                        end
                    end

                    crc: begin
                        if (idx == 2'd0) begin
                            lo_byte <= byte_beat.data;
                            idx     <= 2'd1;
                        end else begin
                            crc_error <= ({byte_beat.data, lo_byte} != crc_acc);
                            state     <= pad;
                        end
                    end

                    // padding and stray bytes wait for the next sop
                    default: ;
                endcase
            end
        end
    end

endmodule

/* rtl/csi2_raw10_unpack.sv */
// ----------------------------------------------------------
// RAW10 unpacker
// five payload bytes become four 10-bit pixels, byte 4 holds
// the low two bits of each pixel
// ----------------------------------------------------------

module csi2_raw10_unpack (
    input  logic                        aclk,
    input  logic                        aresetn,
    input  logic                        payload_valid,
    input  csi2_rx_pkg::payload_beat_t  payload_beat,
    output logic                        pix_valid,
    output csi2_rx_pkg::pixel_beat_t    pix_beat
);

    import csi2_rx_pkg::*;

    logic [2:0] idx;
    logic [1:0] pending;
    byte_t      grp [4];
    logic       grp_fs;
    pixel_t     hold [3];
    logic       hold_last;

    logic       group_done;

    assign group_done = payload_valid && (idx == 3'd4);

    // ------------------------------------------------------
    // group and output counters
    // ------------------------------------------------------
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            idx       <= '0;
            pending   <= '0;
            pix_valid <= 1'b0;
        end else begin
            pix_valid <= 1'b0;
            if (pending != '0) begin
                pix_valid <= 1'b1;
                pending   <= pending - 1'b1;
            end
            if (group_done) begin
                idx       <= '0;
                pix_valid <= 1'b1;
                pending   <= 2'd3;
            end else if (payload_valid && payload_beat.last) begin
                // short line, partial group is dropped
                idx <= '0;
            end else if (payload_valid) begin
                idx <= idx + 1'b1;
            end
        end
    end

    // ------------------------------------------------------
    // pixel data
    // ------------------------------------------------------
    always_ff @(posedge aclk) begin
        if (payload_valid && !group_done) begin
            grp[idx[1:0]] <= payload_beat.data;
            if (idx == 3'd0) begin
                grp_fs <= payload_beat.fs;
            end
        end

        if (group_done) begin
            pix_beat.data <= {grp[0], payload_beat.data[1:0]};
            pix_beat.user <= grp_fs;
            pix_beat.last <= 1'b0;
            for (int i = 1; i < 4; i++) begin
                hold[i-1] <= {grp[i], payload_beat.data[2*i +: 2]};
            end
            hold_last <= payload_beat.last;
        end else if (pending != '0) begin
            pix_beat.data <= hold[0];
            pix_beat.user <= 1'b0;
            pix_beat.last <= hold_last && (pending == 2'd1);
            hold[0]       <= hold[1];
            hold[1]       <= hold[2];
        end
    end

endmodule

/* rtl/csi2_pixel_fifo.sv */
// ----------------------------------------------------------
// synchronous show-ahead pixel FIFO
// head entry is presented on the output, a write while full
// is dropped and raises overflow until reset
// ----------------------------------------------------------

module csi2_pixel_fifo #(
    parameter int fifo_addr_width = 4
) (
    input  logic                      aclk,
    input  logic                      aresetn,
    input  logic                      pix_valid,
    input  csi2_rx_pkg::pixel_beat_t  pix_beat,
    output logic                      m_tvalid,
    output csi2_rx_pkg::pixel_beat_t  m_tbeat,
    input  logic                      m_tready,
    output logic                      overflow
);

    import csi2_rx_pkg::*;

    localparam int depth = 2 ** fifo_addr_width;

    pixel_beat_t                mem [depth];
    logic [fifo_addr_width:0]   wr_ptr;
    logic [fifo_addr_width:0]   rd_ptr;
    logic                       full;

    // extra pointer bit tells full from empty
    assign full = (wr_ptr[fifo_addr_width] != rd_ptr[fifo_addr_width]) &&
                  (wr_ptr[fifo_addr_width-1:0] == rd_ptr[fifo_addr_width-1:0]);

    assign m_tvalid = (wr_ptr != rd_ptr);
    assign m_tbeat  = mem[rd_ptr[fifo_addr_width-1:0]];

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            overflow <= 1'b0;
        end else begin
            if (pix_valid && !full) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pix_valid && full) begin
                overflow <= 1'b1;
            end
            if (m_tvalid && m_tready) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // storage
    always_ff @(posedge aclk) begin
        if (pix_valid && !full) begin
            mem[wr_ptr[fifo_addr_width-1:0]] <= pix_beat;
        end
    end

endmodule

/* rtl/csi2_rx.sv */
// ----------------------------------------------------------
// CSI-2 RAW10 receive path, single clock
// lane merge, packet parser, unpacker and output FIFO with
// a valid/ready pixel port (user = frame start, last = line end)
// ----------------------------------------------------------

module csi2_rx #(
    parameter int                       lanes           = 2,
    parameter csi2_rx_pkg::data_type_t  pixel_data_type = csi2_rx_pkg::dt_raw10,
    parameter int                       fifo_addr_width = 4
) (
    input  logic                      aclk,
    input  logic                      aresetn,

    // D-PHY lanes
    input  logic [lanes*8-1:0]        rxdatahs,
    input  logic [lanes-1:0]          rxvalidhs,
    input  logic [lanes-1:0]          rxactivehs,
    input  logic [lanes-1:0]          rxsynchs,

    // pixel output
    output logic                      m_tvalid,
    output csi2_rx_pkg::pixel_beat_t  m_tbeat,
    input  logic                      m_tready,

    // status pulses and flags
    output logic                      frame_start,
    output logic                      frame_end,
    output logic                      crc_error,
    output logic                      overflow
);

    import csi2_rx_pkg::*;

    // a lane only counts while it is in HS receive
    wire [lanes-1:0] lane_valid = rxvalidhs & rxactivehs;

    logic          byte_valid;
    byte_beat_t    byte_beat;
    logic          payload_valid;
    payload_beat_t payload_beat;
    logic          pix_valid;
    pixel_beat_t   pix_beat;

    csi2_lane_merge #(
        .lanes           (lanes)
    ) u_lane_merge (
        .aclk            (aclk),
        .aresetn         (aresetn),
        .rxdatahs        (rxdatahs),
        .rxvalidhs       (lane_valid),
        .rxsynchs        (rxsynchs),
        .byte_valid      (byte_valid),
        .byte_beat       (byte_beat)
    );

    csi2_packet_parser #(
        .pixel_data_type (pixel_data_type)
    ) u_packet_parser (
        .aclk            (aclk),
        .aresetn         (aresetn),
        .byte_valid      (byte_valid),
        .byte_beat       (byte_beat),
        .payload_valid   (payload_valid),
        .payload_beat    (payload_beat),
        .frame_start     (frame_start),
        .frame_end       (frame_end),
        .crc_error       (crc_error)
    );

    csi2_raw10_unpack u_raw10_unpack (
        .aclk            (aclk),
        .aresetn         (aresetn),
        .payload_valid   (payload_valid),
        .payload_beat    (payload_beat),
        .pix_valid       (pix_valid),
        .pix_beat        (pix_beat)
    );

    csi2_pixel_fifo #(
        .fifo_addr_width (fifo_addr_width)
    ) u_pixel_fifo (
        .aclk            (aclk),
        .aresetn         (aresetn),
        .pix_valid       (pix_valid),
        .pix_beat        (pix_beat),
        .m_tvalid        (m_tvalid),
        .m_tbeat         (m_tbeat),
        .m_tready        (m_tready),
        .overflow        (overflow)
    );

endmodule

/* bench/csi2_rx_properties.sv */
// ----------------------------------------------------------
// concurrent checks bound into the CSI-2 receive top level
// output stall, frame pulses, sticky overflow, lane spacing
// ----------------------------------------------------------

module csi2_rx_properties (
    input logic                     aclk,
    input logic                     aresetn,
    input logic                     m_tvalid,
    input csi2_rx_pkg::pixel_beat_t m_tbeat,
    input logic                     m_tready,
    input logic                     frame_start,
    input logic                     frame_end,
    input logic                     overflow,
    input logic                     lane_beat,
    input logic                     merge_busy
);

    timeunit 1ns;
    timeprecision 1ps;

    // number of property failures so far
    int fail_count = 0;

    // stalled head pixel must not move
    a_tbeat_stable: assert property (@(posedge aclk) disable iff (!aresetn)
        m_tvalid && !m_tready |=> m_tvalid && $stable(m_tbeat))
        else begin
            fail_count++;
            $error("output pixel changed while the sink stalled");
        end

    a_frame_pulses: assert property (@(posedge aclk) disable iff (!aresetn)
        !(frame_start && frame_end))
        else begin
            fail_count++;
            $error("frame start and frame end pulsed together");
        end

    // sticky until reset
    a_overflow_sticky: assert property (@(posedge aclk) disable iff (!aresetn)
        overflow |=> overflow)
        else begin
            fail_count++;
            $error("overflow fell without a reset");
        end

    a_lane_spacing: assert property (@(posedge aclk) disable iff (!aresetn)
        lane_beat |-> !merge_busy)
        else begin
            fail_count++;
            $error("lane beat arrived while the merge was still shifting");
        end

endmodule

bind csi2_rx csi2_rx_properties u_properties (
    .aclk        (aclk),
    .aresetn     (aresetn),
    .m_tvalid    (m_tvalid),
    .m_tbeat     (m_tbeat),
    .m_tready    (m_tready),
    .frame_start (frame_start),
    .frame_end   (frame_end),
    .overflow    (overflow),
    .lane_beat   (&lane_valid),
    .merge_busy  (u_lane_merge.remain != '0)
);

/* bench/csi2_rx_tb.sv */
// ----------------------------------------------------------
// testbench for the CSI-2 receive path
// plays a packet table over the lanes, predicts RAW10 pixels
// and pulse counts, and checks the valid/ready pixel port
// ----------------------------------------------------------

module csi2_rx_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import csi2_rx_pkg::*;

    localparam int lanes           = 2;
    localparam int fifo_addr_width = 4;
    localparam int fifo_depth      = 2 ** fifo_addr_width;
    localparam int gap_cycles      = 8;
    localparam int timeout_cycles  = 2000;
    localparam int n_entries       = 13;

    typedef struct {
        data_type_t dt;
        int         wc;
        byte_t      seed;
        bit         bad_crc;
        int         ready_pct;
    } pkt_entry_t;

    // data type, word count, payload seed, inverted CRC, sink ready duty in percent
    pkt_entry_t pkt_table [n_entries] = '{
        '{dt_frame_start, 1,  8'h00, 1'b0, 100},
        '{dt_raw10,       10, 8'h11, 1'b0, 100},
        '{dt_raw10,       10, 8'h5a, 1'b0, 100},
        '{dt_frame_end,   1,  8'h00, 1'b0, 100},
        '{dt_raw10,       10, 8'h23, 1'b1, 100},
        '{dt_raw10,       10, 8'h47, 1'b0, 100},
        '{6'h2a,          12, 8'h6c, 1'b0, 100},
        '{dt_frame_start, 2,  8'h00, 1'b0, 50},
        '{dt_raw10,       20, 8'h31, 1'b0, 50},
        '{dt_raw10,       15, 8'h72, 1'b0, 50},
        '{dt_raw10,       10, 8'h0e, 1'b0, 50},
        '{dt_frame_end,   2,  8'h00, 1'b0, 50},
        '{dt_raw10,       30, 8'h9d, 1'b0, 0}
    };

    logic               aclk = 1'b0;
    logic               aresetn;
    logic [lanes*8-1:0] rxdatahs;
    logic [lanes-1:0]   rxvalidhs;
    logic [lanes-1:0]   rxactivehs;
    logic [lanes-1:0]   rxsynchs;
    logic               m_tvalid;
    pixel_beat_t        m_tbeat;
    logic               m_tready = 1'b0;
    logic               frame_start;
    logic               frame_end;
    logic               crc_error;
    logic               overflow;

    pixel_beat_t exp_q [$];
    int          ready_pct = 100;
    bit          fs_armed;
    int          fs_seen;
    int          fe_seen;
    int          crc_seen;

    always #2 aclk = ~aclk;

    csi2_rx #(
        .lanes           (lanes),
        .pixel_data_type (dt_raw10),
        .fifo_addr_width (fifo_addr_width)
    ) u_dut (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .rxdatahs    (rxdatahs),
        .rxvalidhs   (rxvalidhs),
        .rxactivehs  (rxactivehs),
        .rxsynchs    (rxsynchs),
        .m_tvalid    (m_tvalid),
        .m_tbeat     (m_tbeat),
        .m_tready    (m_tready),
        .frame_start (frame_start),
        .frame_end   (frame_end),
        .crc_error   (crc_error),
        .overflow    (overflow)
    );

    task automatic report_error(input string msg);
        $display("Error at %0t ns: %s", $time, msg);
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    task automatic abort_on_timeout(input string what);
        $display("timed out waiting for %s", what);
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    // ------------------------------------------------------------
    // packet and pixel models
    // ------------------------------------------------------------
    function automatic byte_t payload_byte(input byte_t seed, input int k);
        return byte_t'(((int'(seed) + k) * 29) ^ (k * 8));
    endfunction

    // CSI-2 CRC-16 with each byte folded into the low half
    function automatic crc_t payload_crc(input byte_t pl [$]);
        crc_t c;
        c = 16'hffff;
        foreach (pl[k]) begin
            c[7:0] = c[7:0] ^ pl[k];
            repeat (8) begin
                c = c[0] ? ((c >> 1) ^ 16'h8408) : (c >> 1);
            end
        end
        return c;
    endfunction

    task automatic build_packet(input pkt_entry_t ent, output byte_t pkt [$],
                                output byte_t pl [$]);
        crc_t c;
        pkt = {};
        pl  = {};
        pkt.push_back({2'b00, ent.dt});
        pkt.push_back(byte_t'(ent.wc));
        pkt.push_back(byte_t'(ent.wc >> 8));
        // ECC byte is ignored by the receiver
        pkt.push_back(byte_t'($urandom));
        if (ent.dt >= 6'h10) begin
            for (int k = 0; k < ent.wc; k++) begin
                pl.push_back(payload_byte(ent.seed, k));
                pkt.push_back(pl[k]);
            end
            c = payload_crc(pl);
            if (ent.bad_crc) begin
                c = ~c;
            end
            pkt.push_back(c[7:0]);
            pkt.push_back(c[15:8])
            ;
        end
    endtask

    // five bytes give four pixels with the low bits in byte 4
    task automatic expect_pixels(input byte_t pl [$]);
        pixel_beat_t p;
        byte_t       low;
        for (int g = 0; g < pl.size() / 5; g++) begin
            low = pl[5*g+4];
            for (int i = 0; i < 4; i++) begin
                p.data = {pl[5*g+i], low[2*i +: 2]};
                p.user = fs_armed && (g == 0) && (i == 0);
                p.last = (i == 3) && (5*g + 4 == pl.size() - 1);
                exp_q.push_back(p);
            end
        end
        if (pl.size() > 0) begin
            fs_armed = 1'b0;
        end
    endtask

    // ------------------------------------------------------------
    // lane driver and waits
    // ------------------------------------------------------------
    task automatic send_packet(input byte_t pkt [$]);
        int idx;
        for (int b = 0; b < (pkt.size() + lanes - 1) / lanes; b++) begin
            @(posedge aclk);
            #1;
            for (int l = 0; l < lanes; l++) begin
                idx = b * lanes + l;
                rxdatahs[l*8 +: 8] = (idx < pkt.size()) ? pkt[idx] : 8'h00;
            end
            rxvalidhs = '1;
            rxsynchs  = (b == 0) ? '1 : '0;
            @(posedge aclk);
            #1;
            rxvalidhs = '0;
            rxsynchs  = '0;
            repeat (lanes - 2) @(posedge aclk);
        end
        // line gap between packets
        repeat (gap_cycles) @(posedge aclk);
    endtask

    task automatic wait_drained();
        int cycles;
        cycles = 0;
        do begin
            @(negedge aclk);
            cycles++;
            if (cycles > timeout_cycles) begin
                abort_on_timeout("the expected pixels");
            end
        end while (exp_q.size() != 0);
    endtask

    task automatic wait_overflow();
        int cycles;
        cycles = 0;
        while (!overflow) begin
            @(negedge aclk);
            cycles++;
            if (cycles > timeout_cycles) begin
                abort_on_timeout("the overflow flag");
            end
        end
    endtask

    // ------------------------------------------------------------
    // output checker and sink
    // ------------------------------------------------------------
    always @(posedge aclk) begin
        pixel_beat_t want;
        if (aresetn && m_tvalid && m_tready) begin
            assert (exp_q.size() != 0)
                else report_error($sformatf("unexpected pixel %h", m_tbeat));
            want = exp_q.pop_front();
            assert (m_tbeat == want)
                else report_error($sformatf("pixel %h, expected %h", m_tbeat, want));
        end
        #1;
        if (!aresetn || ready_pct == 0) begin
            m_tready = 1'b0;
        end else if (ready_pct >= 100) begin
            m_tready = 1'b1;
        end else begin
            m_tready = (($urandom % 100) < ready_pct);
        end
    end

    // pulse counters
    always @(posedge aclk) begin
        if (aresetn) begin
            fs_seen  = fs_seen + int'(frame_start);
            fe_seen  = fe_seen + int'(frame_end);
            crc_seen = crc_seen + int'(crc_error);
        end
    end

    // bound property failures end the run
    always @(negedge aclk) begin
        assert (u_dut.u_properties.fail_count == 0)
            else report_error("a bound property check failed");
    end

    // ------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------
    initial begin
        pkt_entry_t ent;
        byte_t      pkt [$];
        byte_t      pl [$];
        int         exp_fs;
        int         exp_fe;
        int         exp_crc;
        bit         exp_ovf;

        void'($urandom(32'h3f00_2ec0));
        aresetn    = 1'b0;
        rxdatahs   = '0;
        rxvalidhs  = '0;
        rxactivehs = '0;
        rxsynchs   = '0;
        fs_armed   = 1'b0;
        fs_seen    = 0;
        fe_seen    = 0;
        crc_seen   = 0;
        exp_fs     = 0;
        exp_fe     = 0;
        exp_crc    = 0;
        exp_ovf    = 1'b0;

        repeat (2) @(posedge aclk);
        #1;
        aresetn    = 1'b1;
        rxactivehs = '1;
        @(negedge aclk);
        assert (!m_tvalid && !overflow && !frame_start && !frame_end && !crc_error)
            else report_error("outputs not low after reset");

        for (int e = 0; e < n_entries; e++) begin
            ent = pkt_table[e];
            build_packet(ent, pkt, pl);
            if (ent.dt == dt_frame_start) begin
                fs_armed = 1'b1;
                exp_fs++;
            end else if (ent.dt == dt_frame_end) begin
                exp_fe++;
            end else begin
                if (ent.dt == dt_raw10) begin
                    expect_pixels(pl);
                end
                exp_crc += int'(ent.bad_crc);
            end
            if (ent.ready_pct == 0) begin
                // a stalled sink only gets what the FIFO could hold
                while (exp_q.size() > fifo_depth) begin
                    void'(exp_q.pop_back());
                end
                exp_ovf = 1'b1;
            end

            ready_pct = ent.ready_pct;
            send_packet(pkt);
            if (ent.ready_pct == 0) begin
                wait_overflow();
                ready_pct = 100;
            end
            wait_drained();

            assert (!m_tvalid)
                else report_error($sformatf("extra pixel %h after entry %0d", m_tbeat, e));
            assert (fs_seen == exp_fs && fe_seen == exp_fe)
                else report_error($sformatf("frame pulses %0d/%0d, expected %0d/%0d",
                                            fs_seen, fe_seen, exp_fs, exp_fe));
            assert (crc_seen == exp_crc)
                else report_error($sformatf("crc_error pulsed %0d times, expected %0d",
                                            crc_seen, exp_crc));
            assert (overflow == exp_ovf)
                else report_error($sformatf("overflow %b, expected %b", overflow, exp_ovf));
        end

        assert (u_dut.u_properties.fail_count == 0)
            else report_error("a bound property check failed");

        $display("TESTS PASSED");
        $finish;
    end

endmodule

/* build.f */
rtl/csi2_rx_pkg.sv
rtl/csi2_lane_merge.sv
rtl/csi2_packet_parser.sv
rtl/csi2_raw10_unpack.sv
rtl/csi2_pixel_fifo.sv
rtl/csi2_rx.sv
bench/csi2_rx_properties.sv
bench/csi2_rx_tb.sv

/* Bender.yml */
package:
  name: csi2_rx

sources:
  - files:
      - rtl/csi2_rx_pkg.sv
      - rtl/csi2_lane_merge.sv
      - rtl/csi2_packet_parser.sv
      - rtl/csi2_raw10_unpack.sv
      - rtl/csi2_pixel_fifo.sv
      - rtl/csi2_rx.sv
  - target: test
    files:
      - bench/csi2_rx_properties.sv
      - bench/csi2_rx_tb.sv
